//--- hw/audio_consts.svh
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// clk_m cycles per mic_clk period, mic_clk high for the first half
`define PDM_CLK_DIV 8

// PDM bits tallied into one PCM sample
`define DECIM_LEN 64

// PCM samples reduced into one frame result
`define FRAME_LEN 8

`define PEAK_FLOOR 8   // frames quieter than this never count as a match

// match tolerance is the template shifted right by this amount
`define MATCH_SHIFT 2

`define SAMPLE_W 8

`endif

//--- hw/audio_pkg.sv
`include "audio_consts.svh"

package audio_pkg;

  // ones count in a window minus half the window length
  typedef logic signed [`SAMPLE_W-1:0] pcm_sample_t;

  typedef logic [11:0] frame_energy_t;  // sum of magnitudes over a frame
  typedef logic [7:0] peak_mag_t;  // largest magnitude in a frame

  typedef enum logic {
    DET_EMPTY,
    DET_ARMED
  } detect_state_e;

  // per-frame opcode, decoded from the enroll input
  typedef enum logic {
    MODE_DETECT,
    MODE_ENROLL
  } detect_mode_e;

endpackage

//--- hw/energy_if.sv
`timescale 1ns/10ps

interface energy_if
  import audio_pkg::*;
();

  logic valid;
  logic ready;
  frame_energy_t energy;
  peak_mag_t peak;

  // frame result producer
  modport src (output valid, output energy, output peak, input ready);

  // frame result consumer
  modport dst (input valid, input energy, input peak, output ready);

endinterface

//--- hw/pdm_decimator.sv
`timescale 1ns/10ps
`include "audio_consts.svh"

module pdm_decimator
  import audio_pkg::*;
(
  input  logic        clk_m,
  input  logic        rst_in,
  input  logic        mic_data,
  output logic        mic_clk,
  output logic        tick,
  output logic        pcm_valid,
  output pcm_sample_t pcm_sample
);

  localparam int DIV_W = $clog2(`PDM_CLK_DIV);
  localparam int BIT_W = $clog2(`DECIM_LEN);
  localparam int ONES_W = $clog2(`DECIM_LEN + 1);

  logic [DIV_W-1:0] div_cnt;
  logic mic_clk_d;
  logic [BIT_W-1:0] bit_cnt;
  logic [ONES_W-1:0] ones;
  logic [ONES_W-1:0] ones_next;
  logic window_done;

  always_ff @(posedge clk_m) begin
    if (rst_in) begin
      div_cnt <= '0;
      mic_clk <= 1'b0;
      mic_clk_d <= 1'b0;
    end else begin
      div_cnt <= (div_cnt == DIV_W'(`PDM_CLK_DIV - 1)) ? '0 : div_cnt + 1'b1;
      mic_clk <= div_cnt < DIV_W'(`PDM_CLK_DIV / 2);
      mic_clk_d <= mic_clk;
    end
  end

  // one cycle after the registered clock rises
  assign tick = mic_clk & ~mic_clk_d;

  assign ones_next = ones + ONES_W'(mic_data);
  assign window_done = tick && (bit_cnt == BIT_W'(`DECIM_LEN - 1));

  always_ff @(posedge clk_m) begin
    if (rst_in) begin
      bit_cnt <= '0;
      ones <= '0;
      pcm_valid <= 1'b0;
    end else begin
      pcm_valid <= window_done;
      if (tick) begin
        bit_cnt <= window_done ? '0 : bit_cnt + 1'b1;
        ones <= window_done ? '0 : ones_next;
      end
    end
  end

  // centre the tally so silence sits at zero
  always_ff @(posedge clk_m) begin
    if (window_done) begin
      pcm_sample <= pcm_sample_t'(ones_next) - pcm_sample_t'(`DECIM_LEN / 2);
    end
  end

endmodule

//--- hw/frame_energy.sv
`timescale 1ns/10ps
`include "audio_consts.svh"

module frame_energy
  import audio_pkg::*;
(
  input  logic        clk_m,
  input  logic        rst_in,
  input  logic        pcm_valid,
  input  pcm_sample_t pcm_sample,
  output logic        sample_ready,
  energy_if.src       eo
);

  localparam int CNT_W = $clog2(`FRAME_LEN + 1);

  logic [CNT_W-1:0] count;
  frame_energy_t acc_energy;
  peak_mag_t acc_peak;
  peak_mag_t mag;
  frame_energy_t energy_next;
  peak_mag_t peak_next;
  logic accept;
  logic last_sample;
  logic transfer;

  assign sample_ready = ~eo.valid;  // nothing is taken while a result waits
  assign accept = pcm_valid & sample_ready;
  assign transfer = eo.valid & eo.ready;
  assign last_sample = accept && (count == CNT_W'(`FRAME_LEN - 1));

  assign mag = peak_mag_t'((pcm_sample < 0) ? -pcm_sample : pcm_sample);
  assign energy_next = acc_energy + frame_energy_t'(mag);
  assign peak_next = (mag > acc_peak) ? mag : acc_peak;

  always_ff @(posedge clk_m) begin
    if (rst_in) begin
      count <= '0;
      acc_energy <= '0;
      acc_peak <= '0;
      eo.valid <= 1'b0;
    end else if (transfer) begin
      count <= '0;  // new frame starts once the result is taken
      acc_energy <= '0;
      acc_peak <= '0;
      eo.valid <= 1'b0;
    end else if (accept) begin
      count <= count + 1'b1;
      acc_energy <= energy_next;
      acc_peak <= peak_next;
      eo.valid <= last_sample;
    end
  end

  // holding register, stable until the detector takes it
  always_ff @(posedge clk_m) begin
    if (last_sample) begin
      eo.energy <= energy_next;
      eo.peak <= peak_next;
    end
  end

endmodule

//--- hw/voice_detector.sv
`timescale 1ns/10ps
`include "audio_consts.svh"

module voice_detector
  import audio_pkg::*;
(
  input  logic  clk_m,
  input  logic  rst_in,
  input  logic  enroll,
  energy_if.dst ei,
  output logic  detect_valid,
  output logic  detected,
  output logic  enrolled
);

  detect_state_e state;
  detect_mode_e mode;
  frame_energy_t template_energy;
  frame_energy_t diff;
  frame_energy_t tolerance;
  logic transfer;
  logic match;

  assign ei.ready = 1'b1;  // the detector keeps up with every frame
  assign transfer = ei.valid & ei.ready;

  assign mode = enroll ? MODE_ENROLL : MODE_DETECT;

  assign diff = (ei.energy >= template_energy) ? ei.energy - template_energy
                                               : template_energy - ei.energy;
  assign tolerance = template_energy >> `MATCH_SHIFT;

  // loud enough and close enough to the stored frame
  assign match = (state == DET_ARMED) &&
                 (ei.peak >= peak_mag_t'(`PEAK_FLOOR)) &&
                 (diff <= tolerance);

  always_ff @(posedge clk_m) begin
    if (rst_in) begin
      state <= DET_EMPTY;
      template_energy <= '0;
      detect_valid <= 1'b0;
      detected <= 1'b0;
    end else begin
      detect_valid <= transfer;
      if (transfer) begin
        case (mode)
          MODE_ENROLL: begin
            template_energy <= ei.energy;
            state <= DET_ARMED;
            detected <= 1'b0;
          end
          default: begin
            detected <= match;
          end
        endcase
      end
    end
  end

  assign enrolled = (state == DET_ARMED);

endmodule

//--- hw/pdm_modulator.sv
`timescale 1ns/10ps

module pdm_modulator
  import audio_pkg::*;
(
  input  logic        clk_m,
  input  logic        rst_in,
  input  logic        tick,
  input  pcm_sample_t level,
  output logic        spk
);

  logic signed [8:0] error;
  logic signed [8:0] feedback;

  // subtract the value the last output bit stood for
  assign feedback = (error > 0) ? 9'sd127 : -9'sd128;

  always_ff @(posedge clk_m) begin
    if (rst_in) begin
      error <= '0;
    end else if (tick) begin
      error <= error + 9'(level) - feedback;
    end
  end

  assign spk = error > 0;

endmodule

//--- hw/audio_frontend_top.sv
`timescale 1ns/10ps

module audio_frontend_top
  import audio_pkg::*;
(
  input  logic        clk_m,
  input  logic        rst_in,
  input  logic        mic_data,
  input  logic        enroll,
  output logic        mic_clk,
  output logic        spk,
  output logic        pcm_valid,
  output pcm_sample_t pcm_sample,
  output logic        detect_valid,
  output logic        detected,
  output logic        enrolled,
  output logic        overrun
);

  logic tick;
  logic sample_ready;
  pcm_sample_t latest_sample;

  energy_if e_if ();

  pdm_decimator pdm_decimator_inst (
    .clk_m(clk_m),
    .rst_in(rst_in),
    .mic_data(mic_data),
    .mic_clk(mic_clk),
    .tick(tick),
    .pcm_valid(pcm_valid),
    .pcm_sample(pcm_sample)
  );

  frame_energy frame_energy_inst (
    .clk_m(clk_m),
    .rst_in(rst_in),
    .pcm_valid(pcm_valid),
    .pcm_sample(pcm_sample),
    .sample_ready(sample_ready),
    .eo(e_if.src)
  );

  voice_detector voice_detector_inst (
    .clk_m(clk_m),
    .rst_in(rst_in),
    .enroll(enroll),
    .ei(e_if.dst),
    .detect_valid(detect_valid),
    .detected(detected),
    .enrolled(enrolled)
  );

  pdm_modulator pdm_modulator_inst (
    .clk_m(clk_m),
    .rst_in(rst_in),
    .tick(tick),
    .level(latest_sample),
    .spk(spk)
  );

  // the mic cannot stall, so a refused sample is lost and remembered here
  always_ff @(posedge clk_m) begin
    if (rst_in) begin
      latest_sample <= '0;
      overrun <= 1'b0;
    end else begin
      if (pcm_valid) latest_sample <= pcm_sample;  // playback level
      if (pcm_valid && !sample_ready) overrun <= 1'b1;
    end
  end

endmodule

//--- bench/tb_audio_frontend.sv
`timescale 1ns/10ps
`include "audio_consts.svh"

module tb_audio_frontend
  import audio_pkg::*;
();

  localparam int NUM_FRAMES = 8;
  localparam int NUM_WIN = NUM_FRAMES * `FRAME_LEN;
  localparam int ENROLL_FRAME = 2;
  localparam int PLAY_FRAME = 6;
  localparam int PLAY_K = 48;
  localparam int PLAY_TICKS = 255;
  localparam int RUN_LIMIT = 40000;

  logic clk_m = 1'b0;
  logic rst_in;
  logic mic_data;
  logic enroll;
  logic mic_clk;
  logic spk;
  logic pcm_valid;
  pcm_sample_t pcm_sample;
  logic detect_valid;
  logic detected;
  logic enrolled;
  logic overrun;

  logic mic_clk_q;
  logic tick_seen;

  int win_k [NUM_WIN];
  int k_queue [$];
  int energy_q [$];
  int peak_q [$];
  int frame_buf [`FRAME_LEN];
  int frame_fill = 0;
  int win_idx;
  int bit_idx;
  int cur_k;
  int pcm_count = 0;
  int detect_count = 0;
  bit ref_armed = 1'b0;
  int ref_template = 0;
  bit overrun_seen = 1'b0;
  int sample_errs = 0;
  int detect_errs = 0;
  int overrun_errs = 0;
  int check_errs = 0;

  audio_frontend_top audio_frontend_top_inst (
    .clk_m(clk_m),
    .rst_in(rst_in),
    .mic_data(mic_data),
    .enroll(enroll),
    .mic_clk(mic_clk),
    .spk(spk),
    .pcm_valid(pcm_valid),
    .pcm_sample(pcm_sample),
    .detect_valid(detect_valid),
    .detected(detected),
    .enrolled(enrolled),
    .overrun(overrun)
  );

  always #10 clk_m = ~clk_m;

  always @(posedge clk_m) mic_clk_q <= mic_clk;
  assign tick_seen = mic_clk & ~mic_clk_q;  // the cycle on which the mic bit is taken

  function automatic int expected_sample(input int k);
    return k - `DECIM_LEN / 2;
  endfunction

  // bit j of a window that holds k ones spread evenly
  function automatic bit spread_bit(input int k, input int j);
    return ((j + 1) * k) / `DECIM_LEN != (j * k) / `DECIM_LEN;
  endfunction

  task automatic frame_result(input int samples [`FRAME_LEN], output int energy,
                              output int peak);
    int mag;
    energy = 0;
    peak = 0;
    for (int i = 0; i < `FRAME_LEN; i++) begin
      mag = (samples[i] < 0) ? -samples[i] : samples[i];
      energy += mag;
      if (mag > peak) peak = mag;
    end
  endtask

  function automatic bit detect_rule(input bit armed, input int templ, input int energy,
                                     input int peak);
    int diff;
    diff = (energy > templ) ? energy - templ : templ - energy;
    return armed && (peak >= `PEAK_FLOOR) && (diff <= (templ >> `MATCH_SHIFT));
  endfunction

  // ones counts per window are random at first and chosen per frame after that
  task automatic build_schedule();
    int match_k [`FRAME_LEN] = '{42, 30, 38, 26, 38, 26, 38, 26};  // energy 48, peak 10
    int quiet_k [`FRAME_LEN] = '{39, 25, 39, 25, 39, 25, 37, 27};  // energy 52, peak 7
    for (int w = 0; w < NUM_WIN; w++) begin
      case (w / `FRAME_LEN)
        0, 1: win_k[w] = $urandom_range(`DECIM_LEN, 0);
        ENROLL_FRAME: win_k[w] = 38;  // template energy 48
        3: win_k[w] = match_k[w % `FRAME_LEN];
        4: win_k[w] = 52;  // far louder than the template
        5: win_k[w] = quiet_k[w % `FRAME_LEN];
        default: win_k[w] = PLAY_K;
      endcase
    end
    win_k[0] = 0;
    win_k[1] = `DECIM_LEN;
  endtask

  task automatic expect_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s expected %0b, actual %0b", $time, name, expected, actual);
      check_errs++;
    end
  endtask

  task automatic wait_tick(input int limit, output int cycles, output bit found);
    cycles = 0;
    do begin
      @(posedge clk_m);
      cycles++;
    end while (!tick_seen && cycles < limit);
    found = tick_seen;
  endtask

  // the mic stream gives one bit per tick and the next bit is driven on the edge that takes
  // the current one
  always @(posedge clk_m) begin
    if (rst_in) begin
      win_idx = 0;
      bit_idx = 0;
      cur_k = win_k[0];
      mic_data <= spread_bit(cur_k, 0);
      enroll <= 1'b0;
    end else if (tick_seen) begin
      if (bit_idx == 0) begin
        k_queue.push_back(cur_k);
        enroll <= (win_idx / `FRAME_LEN == ENROLL_FRAME);
      end
      bit_idx++;
      if (bit_idx == `DECIM_LEN) begin
        bit_idx = 0;
        win_idx++;
        cur_k = (win_idx < NUM_WIN) ? win_k[win_idx] : `DECIM_LEN / 2;
      end
      mic_data <= spread_bit(cur_k, bit_idx);
    end
  end

  always @(posedge clk_m) begin
    int k;
    int exp_s;
    int e;
    int p;
    if (!rst_in && pcm_valid) begin
      if (k_queue.size() == 0) begin
        $display("%0d ns: pcm_valid pulsed with no window in flight", $time);
        sample_errs++;
      end else begin
        k = k_queue.pop_front();
        exp_s = expected_sample(k);
        if (pcm_sample !== pcm_sample_t'(exp_s)) begin
          $display("Fail at %0d ns: pcm_sample expected %0d, actual %0d",
                   $time, exp_s, pcm_sample);
          sample_errs++;
        end
        frame_buf[frame_fill] = exp_s;
        frame_fill++;
        if (frame_fill == `FRAME_LEN) begin
          frame_result(frame_buf, e, p);
          energy_q.push_back(e);
          peak_q.push_back(p);
          frame_fill = 0;
        end
      end
      pcm_count <= pcm_count + 1;
    end
  end

  always @(posedge clk_m) begin
    int e;
    int p;
    bit exp_det;
    if (!rst_in && detect_valid) begin
      if (energy_q.size() == 0) begin
        $display("%0d ns: detect_valid pulsed without a finished frame", $time);
        detect_errs++;
      end else begin
        e = energy_q.pop_front();
        p = peak_q.pop_front();
        if (detect_count == ENROLL_FRAME) begin
          ref_template = e;
          ref_armed = 1'b1;
          exp_det = 1'b0;
        end else begin
          exp_det = detect_rule(ref_armed, ref_template, e, p);
        end
        if (detected !== exp_det) begin
          $display("Fail at %0d ns: detected expected %0b, actual %0b", $time, exp_det, detected);
          detect_errs++;
        end
        if (enrolled !== ref_armed) begin
          $display("Fail at %0d ns: enrolled expected %0b, actual %0b",
                   $time, ref_armed, enrolled);
          detect_errs++;
        end
      end
      detect_count <= detect_count + 1;
    end
  end

  always @(posedge clk_m) begin
    if (!rst_in && overrun !== 1'b0 && !overrun_seen) begin
      $display("Fail at %0d ns: overrun expected 0, actual %0b", $time, overrun);
      overrun_errs++;
      overrun_seen = 1'b1;
    end
  end

  initial begin
    int cycles;
    int ticks;
    int highs;
    int level;
    bit found;
    bit timed_out;
    timed_out = 1'b0;
    rst_in = 1'b1;
    mic_data = 1'b0;
    enroll = 1'b0;
    void'($urandom(32'hafca_474f));
    build_schedule();
    repeat (5) @(posedge clk_m);
    rst_in <= 1'b0;

    expect_bit("mic_clk", 1'b0, mic_clk);  // values left by reset
    expect_bit("pcm_valid", 1'b0, pcm_valid);
    expect_bit("detect_valid", 1'b0, detect_valid);
    expect_bit("detected", 1'b0, detected);
    expect_bit("enrolled", 1'b0, enrolled);
    expect_bit("overrun", 1'b0, overrun);

    wait_tick(4 * `PDM_CLK_DIV, cycles, found);
    if (found) wait_tick(4 * `PDM_CLK_DIV, cycles, found);
    if (!found) begin
      $display("%0d ns: mic_clk never started toggling after reset", $time);
      timed_out = 1'b1;
      check_errs++;
    end else if (cycles != `PDM_CLK_DIV) begin
      $display("Fail at %0d ns: mic_clk period expected %0d, actual %0d",
               $time, `PDM_CLK_DIV, cycles);
      check_errs++;
    end

    // playback starts once the first constant window has reached the modulator
    cycles = 0;
    while (!timed_out && pcm_count <= PLAY_FRAME * `FRAME_LEN && cycles < RUN_LIMIT) begin
      @(posedge clk_m);
      cycles++;
    end
    if (!timed_out && pcm_count <= PLAY_FRAME * `FRAME_LEN) begin
      $display("%0d ns: timed out waiting for the playback windows", $time);
      timed_out = 1'b1;
      check_errs++;
    end

    ticks = 0;
    highs = 0;
    cycles = 0;
    while (!timed_out && ticks < PLAY_TICKS && cycles < 2 * PLAY_TICKS * `PDM_CLK_DIV) begin
      @(posedge clk_m);
      cycles++;
      if (tick_seen) begin
        ticks++;
        if (spk) highs++;
      end
    end
    if (!timed_out && ticks < PLAY_TICKS) begin
      $display("%0d ns: timed out counting speaker ticks", $time);
      timed_out = 1'b1;
      check_errs++;
    end else if (!timed_out) begin
      level = expected_sample(PLAY_K) + 128;
      if (highs < level - 2 || highs > level + 2) begin
        $display("Fail at %0d ns: spk high count expected %0d +/- 2, actual %0d",
                 $time, level, highs);
        check_errs++;
      end
    end

    cycles = 0;
    while (!timed_out && detect_count < NUM_FRAMES && cycles < RUN_LIMIT) begin
      @(posedge clk_m);
      cycles++;
    end
    if (!timed_out && detect_count < NUM_FRAMES) begin
      $display("%0d ns: timed out waiting for the detector results", $time);
      timed_out = 1'b1;
      check_errs++;
    end

    $display("errors: %0d sample, %0d detector, %0d overrun, %0d other",
             sample_errs, detect_errs, overrun_errs, check_errs);
    if (sample_errs + detect_errs + overrun_errs + check_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/audio_pkg.sv
hw/energy_if.sv
hw/pdm_decimator.sv
hw/frame_energy.sv
hw/voice_detector.sv
hw/pdm_modulator.sv
hw/audio_frontend_top.sv
bench/tb_audio_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the audio front end testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

top=tb_audio_frontend
build_dir=obj_dir
log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

echo "building ${top}"
if ! verilator --binary --timing -Wno-fatal --top-module "${top}" \
    -Mdir "${build_dir}" -o "${top}" -f project.f; then
  echo "build failed"
  exit 1
fi

echo "running ${top}"
if ! "./${build_dir}/${top}" > "${log}" 2>&1; then
  cat "${log}"
  echo "simulation returned an error status"
  exit 1
fi
cat "${log}"

if grep -q "Test failed" "${log}"; then
  echo "FAIL, see ${log}"
  exit 1
fi

echo "PASS"
exit 0
